//--- vlog.f
common/id_pkg.sv
design/gpr_file.sv
decode/inst_decoder.sv
design/bypass_unit.sv
design/branch_unit.sv
design/id_stage_reg.sv
design/id_stage.sv
testbench/tb_clk_gen.sv
testbench/id_stage_tb.sv

//--- testbench/id_stage_tb.sv
// decode stage testbench: instruction encoders, directed tests, checks and report
`timescale 1ns/1ps

module id_stage_tb;

  localparam int XLEN       = 64;
  localparam int WAIT_LIMIT = 50;

  logic            clk;
  logic            rst_n;
  logic            fs_valid;
  logic [31:0]     fs_inst;
  logic [XLEN-1:0] fs_pc;
  logic            es_allowin;
  logic [4:0]      es_rd;
  logic [XLEN-1:0] es_result;
  logic [4:0]      ms_rd;
  logic [XLEN-1:0] ms_result;
  logic [4:0]      ws_rd;
  logic [XLEN-1:0] ws_result;
  logic            es_load;
  logic            ms_data_stall;
  logic            rf_wen;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;
  logic            ds_allowin;
  logic            ds_to_es_valid;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] pc;
  logic [4:0]      rd;
  logic [1:0]      alu_op;
  logic            alu_src2_imm;
  logic            gpr_wen;
  logic            mem_ren;
  logic            mem_wen;
  logic            ebreak;
  logic            invalid_inst;
  logic            br_taken;
  logic [XLEN-1:0] br_target;
  logic            br_stall;
  logic [XLEN-1:0] ref_regs [32]; // expected register file contents
  int              test_errs;
  int              total_errs;
  int              tests_run;
  int              tests_failed;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  id_stage #(.XLEN(XLEN)) u_id_stage (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_fs_valid(fs_valid), .i_fs_inst(fs_inst), .i_fs_pc(fs_pc), .o_ds_allowin(ds_allowin),
    .o_ds_to_es_valid(ds_to_es_valid), .i_es_allowin(es_allowin),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_imm(imm), .o_pc(pc), .o_rd(rd),
    .o_alu_op(alu_op), .o_alu_src2_imm(alu_src2_imm), .o_gpr_wen(gpr_wen),
    .o_mem_ren(mem_ren), .o_mem_wen(mem_wen), .o_ebreak(ebreak),
    .o_invalid_inst(invalid_inst),
    .i_es_rd(es_rd), .i_es_result(es_result), .i_ms_rd(ms_rd), .i_ms_result(ms_result),
    .i_ws_rd(ws_rd), .i_ws_result(ws_result), .i_es_load(es_load),
    .i_ms_data_stall(ms_data_stall),
    .i_rf_wen(rf_wen), .i_rf_waddr(rf_waddr), .i_rf_wdata(rf_wdata),
    .o_br_taken(br_taken), .o_br_target(br_target), .o_br_stall(br_stall)
  );

  // rv64 encodings, immediates given as their full value
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] src2,
                                         input logic [4:0] src1, input logic [4:0] dst);
    return {f7, src2, src1, 3'b000, dst, id_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [XLEN-1:0] value, input logic [4:0] src1,
                                         input logic [2:0] f3, input logic [4:0] dst,
                                         input logic [6:0] opc);
    return {value[11:0], src1, f3, dst, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [XLEN-1:0] value, input logic [4:0] src2,
                                         input logic [4:0] src1);
    return {value[11:5], src2, src1, 3'b011, value[4:0], id_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [XLEN-1:0] value, input logic [4:0] src2,
                                         input logic [4:0] src1, input logic [2:0] f3);
    return {value[12], value[10:5], src2, src1, f3, value[4:1], value[11], id_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [XLEN-1:0] value, input logic [4:0] dst);
    return {value[20], value[10:1], value[11], value[19:12], dst, id_pkg::OPC_JAL};
  endfunction

  function automatic logic watched(input int sel);
    case (sel)
      0: return rst_n;
      1: return ds_allowin;
      default: return ds_to_es_valid;
    endcase
  endfunction

  // polls at falling edges until the selected signal is high
  task automatic wait_until(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!watched(sel) && (n < WAIT_LIMIT)) begin
      n++;
      @(negedge clk);
    end
    if (!watched(sel)) begin
      $display("timeout while waiting for %s", what);
      $display("Something failed");
      $finish;
    end
  endtask

  task automatic check_val(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s = %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  // flags are {src2_imm, gpr_wen, mem_ren, mem_wen, ebreak, invalid}
  task automatic check_fields(input logic [4:0] e_rd, input logic [XLEN-1:0] e_imm,
                              input logic [1:0] e_alu, input logic [5:0] e_flags,
                              input logic [XLEN-1:0] e_rs1, input logic [XLEN-1:0] e_rs2);
    check_val("o_ds_to_es_valid", ds_to_es_valid, 1);
    check_val("o_rd", rd, e_rd);
    check_val("o_imm", imm, e_imm);
    if (!$isunknown(e_alu)) check_val("o_alu_op", alu_op, e_alu);
    check_val("{src2_imm,gpr_wen,mem_ren,mem_wen,ebreak,invalid_inst}",
              {alu_src2_imm, gpr_wen, mem_ren, mem_wen, ebreak, invalid_inst}, e_flags);
    check_val("o_rs1_data", rs1_data, e_rs1);
    check_val("o_rs2_data", rs2_data, e_rs2);
  endtask

  // one word through fetch, returns at the falling edge after capture
  task automatic issue(input logic [31:0] inst, input logic [XLEN-1:0] inst_pc);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_inst  <= inst;
    fs_pc    <= inst_pc;
    wait_until(1, "o_ds_allowin before capture");
    @(posedge clk);
    fs_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
    @(posedge clk);
    rf_wen   <= 1'b1;
    rf_waddr <= addr;
    rf_wdata <= data;
    if (addr != 5'd0) ref_regs[addr] = data;
  endtask

  task automatic set_sources(input logic [4:0] e, input logic [4:0] m, input logic [4:0] w);
    @(posedge clk);
    es_rd <= e;
    ms_rd <= m;
    ws_rd <= w;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %-12s passed", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic test_reset();
    wait_until(0, "reset release");
    check_val("o_ds_to_es_valid", ds_to_es_valid, 0);
    check_val("o_br_taken", br_taken, 0);
    check_val("o_ds_allowin", ds_allowin, 1);
    finish_test("reset");
  endtask

  task automatic test_decode();
    for (int i = 1; i < 32; i++) write_reg(5'(i), {$urandom, $urandom});
    repeat (8) write_reg(5'($urandom), {$urandom, $urandom}); // x0 may be hit too
    @(posedge clk);
    rf_wen <= 1'b0;
    issue(i_type(-5, 5'd3, 3'b000, 5'd5, id_pkg::OPC_OPIMM), 64'h1000);
    check_fields(5'd5, -5, id_pkg::ALU_ADD, 6'b110000, ref_regs[3], 0);
    issue(r_type(7'h00, 5'd7, 5'd4, 5'd6), 64'h1004);
    check_fields(5'd6, 0, id_pkg::ALU_ADD, 6'b010000, ref_regs[4], ref_regs[7]);
    issue(r_type(7'h20, 5'd10, 5'd9, 5'd8), 64'h1008);
    check_fields(5'd8, 0, id_pkg::ALU_SUB, 6'b010000, ref_regs[9], ref_regs[10]);
    issue({20'h81234, 5'd11, id_pkg::OPC_LUI}, 64'h100c);
    check_fields(5'd11, 64'hffff_ffff_8123_4000, id_pkg::ALU_PASS_B, 6'b110000, 0, 0);
    issue(i_type(16, 5'd13, 3'b011, 5'd12, id_pkg::OPC_LOAD), 64'h1010);
    check_fields(5'd12, 16, id_pkg::ALU_ADD, 6'b111000, ref_regs[13], 0);
    issue(s_type(-8, 5'd14, 5'd15), 64'h1014);
    check_fields(5'd0, -8, id_pkg::ALU_ADD, 6'b100100, ref_regs[15], ref_regs[14]);
    issue(32'h0010_0073, 64'h1018); // ebreak
    check_fields(5'd0, 0, 2'bxx, 6'b000010, 0, 0);
    issue({25'($urandom), 7'h7f}, 64'h101c); // opcode outside the subset
    check_fields(5'd0, 0, 2'bxx, 6'b000001, 0, 0);
    finish_test("decode");
  endtask

  task automatic test_forward();
    logic [XLEN-1:0] r_es;
    logic [XLEN-1:0] r_ms;
    logic [XLEN-1:0] r_ws;
    r_es = {$urandom, $urandom};
    r_ms = {$urandom, $urandom};
    r_ws = {$urandom, $urandom};
    @(posedge clk);
    es_allowin <= 1'b0; // hold the add while sources change
    es_result  <= r_es;
    ms_result  <= r_ms;
    ws_result  <= r_ws;
    issue(r_type(7'h00, 5'd2, 5'd1, 5'd3), 64'h2000);
    set_sources(5'd1, 5'd1, 5'd2);
    check_val("o_rs1_data", rs1_data, r_es);
    check_val("o_rs2_data", rs2_data, r_ws);
    set_sources(5'd2, 5'd1, 5'd1);
    check_val("o_rs1_data", rs1_data, r_ms);
    check_val("o_rs2_data", rs2_data, r_es);
    set_sources(5'd0, 5'd0, 5'd1);
    check_val("o_rs1_data", rs1_data, r_ws);
    check_val("o_rs2_data", rs2_data, ref_regs[2]);
    set_sources(5'd0, 5'd0, 5'd0);
    @(posedge clk);
    es_allowin <= 1'b1;
    issue(r_type(7'h00, 5'd0, 5'd0, 5'd3), 64'h2004); // x0 sources with rd 0 everywhere
    check_val("o_rs1_data", rs1_data, 0);
    check_val("o_rs2_data", rs2_data, 0);
    finish_test("forward");
  endtask

  task automatic test_stall();
    @(posedge clk);
    es_load <= 1'b1;
    es_rd   <= 5'd5;
    issue(r_type(7'h00, 5'd7, 5'd5, 5'd6), 64'h3000);
    check_val("o_ds_to_es_valid", ds_to_es_valid, 0);
    check_val("o_ds_allowin", ds_allowin, 0);
    @(posedge clk);
    es_load <= 1'b0;
    wait_until(2, "o_ds_to_es_valid after the load left");
    check_val("o_ds_allowin", ds_allowin, 1);
    @(posedge clk);
    es_rd         <= 5'd0;
    ms_rd         <= 5'd7;
    ms_data_stall <= 1'b1;
    issue(r_type(7'h00, 5'd7, 5'd5, 5'd6), 64'h3004);
    check_val("o_ds_to_es_valid", ds_to_es_valid, 0);
    check_val("o_ds_allowin", ds_allowin, 0);
    @(posedge clk);
    ms_data_stall <= 1'b0;
    wait_until(2, "o_ds_to_es_valid after memory data");
    check_val("o_ds_allowin", ds_allowin, 1);
    @(posedge clk);
    ms_rd <= 5'd0;
    es_rd <= 5'd5; // matching alu result, no stall
    issue(r_type(7'h00, 5'd7, 5'd5, 5'd6), 64'h3008);
    check_val("o_ds_to_es_valid", ds_to_es_valid, 1);
    check_val("o_ds_allowin", ds_allowin, 1);
    check_val("o_rs1_data", rs1_data, es_result);
    @(posedge clk);
    es_rd <= 5'd0;
    finish_test("stall");
  endtask

  task automatic check_branch(input logic e_taken, input logic [XLEN-1:0] e_target);
    check_val("o_br_taken", br_taken, e_taken);
    if (e_taken) check_val("o_br_target", br_target, e_target);
  endtask

  task automatic test_branch();
    logic same;
    same = (ref_regs[1] == ref_regs[2]);
    issue(b_type(-16, 5'd1, 5'd1, 3'b000), 64'h4000);
    check_branch(1'b1, 64'h3ff0);
    check_val("o_br_stall", br_stall, 0);
    issue(b_type(24, 5'd2, 5'd1, 3'b000), 64'h4004);
    check_branch(same, 64'h401c);
    issue(b_type(24, 5'd2, 5'd1, 3'b001), 64'h4008);
    check_branch(!same, 64'h4020);
    issue(b_type(-16, 5'd1, 5'd1, 3'b001), 64'h400c);
    check_branch(1'b0, 0);
    @(posedge clk);
    es_load   <= 1'b1; // x1 from a load in execute
    es_rd     <= 5'd1;
    es_result <= ref_regs[2];
    issue(b_type(8, 5'd2, 5'd1, 3'b000), 64'h4010);
    check_branch(1'b1, 64'h4018);
    check_val("o_br_stall", br_stall, 1);
    check_val("o_ds_to_es_valid", ds_to_es_valid, 0);
    @(posedge clk);
    es_load <= 1'b0;
    es_rd   <= 5'd0;
    wait_until(2, "o_ds_to_es_valid after branch stall");
    @(posedge clk);
    es_load <= 1'b1; // same load, branch not taken
    es_rd   <= 5'd1;
    issue(b_type(8, 5'd2, 5'd1, 3'b001), 64'h4110);
    check_branch(1'b0, 0);
    check_val("o_br_stall", br_stall, 0);
    check_val("o_ds_to_es_valid", ds_to_es_valid, 0);
    @(posedge clk);
    es_load <= 1'b0;
    es_rd   <= 5'd0;
    wait_until(2, "o_ds_to_es_valid after branch stall");
    issue(j_type(64'h1_2344, 5'd1), 64'h4014);
    check_branch(1'b1, 64'h1_6358);
    check_val("o_rd", rd, 1);
    // word right behind a taken jal
    @(posedge clk);
    fs_valid <= 1'b1;
    fs_inst  <= j_type(64, 5'd1);
    fs_pc    <= 64'h4020;
    wait_until(1, "o_ds_allowin before jal");
    @(posedge clk);
    fs_inst <= i_type(7, 5'd1, 3'b000, 5'd5, id_pkg::OPC_OPIMM);
    fs_pc   <= 64'h4024;
    @(negedge clk);
    check_val("o_br_taken", br_taken, 1);
    @(posedge clk);
    fs_valid <= 1'b0;
    @(negedge clk);
    check_fields(5'd0, 0, id_pkg::ALU_ADD, 6'b100000, 0, 0);
    check_val("o_pc", pc, 64'h4024);
    check_val("o_br_taken", br_taken, 0);
    finish_test("branch");
  endtask

  task automatic test_backpressure();
    @(posedge clk);
    es_allowin <= 1'b0;
    issue(r_type(7'h00, 5'd7, 5'd4, 5'd6), 64'h5000);
    @(posedge clk);
    fs_valid <= 1'b1; // next word waits in fetch
    fs_inst  <= i_type(3, 5'd1, 3'b000, 5'd9, id_pkg::OPC_OPIMM);
    fs_pc    <= 64'h5004;
    repeat (3) begin
      @(negedge clk);
      check_val("o_ds_allowin", ds_allowin, 0);
      check_val("o_ds_to_es_valid", ds_to_es_valid, 1);
      check_val("o_rs1_data", rs1_data, ref_regs[4]);
      check_val("o_rs2_data", rs2_data, ref_regs[7]);
      check_val("o_imm", imm, 0);
      check_val("o_pc", pc, 64'h5000);
      check_val("o_rd", rd, 6);
    end
    @(posedge clk);
    es_allowin <= 1'b1;
    @(posedge clk);
    fs_valid <= 1'b0;
    @(negedge clk);
    check_val("o_pc", pc, 64'h5004);
    check_val("o_rd", rd, 9);
    finish_test("backpressure");
  endtask

  initial begin
    void'($urandom(32'h7d92));
    fs_valid      = 1'b0;
    fs_inst       = '0;
    fs_pc         = '0;
    es_allowin    = 1'b1;
    es_rd         = '0;
    es_result     = '0;
    ms_rd         = '0;
    ms_result     = '0;
    ws_rd         = '0;
    ws_result     = '0;
    es_load       = 1'b0;
    ms_data_stall = 1'b0;
    rf_wen        = 1'b0;
    rf_waddr      = '0;
    rf_wdata      = '0;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset();
    test_decode();
    test_forward();
    test_stall();
    test_branch();
    test_backpressure();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clk_gen.sv
// clock and reset generator for the decode stage testbench
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk; // 40 ns period
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

//--- design/id_stage.sv
// decode stage top: stage register, decoder, register file, forwarding and branch units
`timescale 1ns/1ps

module id_stage #(
  parameter int XLEN = id_pkg::XLEN_DEFAULT
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  // from fetch
  input  logic                           i_fs_valid,
  input  logic [id_pkg::INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]                i_fs_pc,
  output logic                           o_ds_allowin,
  // to execute
  output logic                           o_ds_to_es_valid,
  input  logic                           i_es_allowin,
  output logic [XLEN-1:0]                o_rs1_data,
  output logic [XLEN-1:0]                o_rs2_data,
  output logic [XLEN-1:0]                o_imm,
  output logic [XLEN-1:0]                o_pc,
  output logic [id_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic [1:0]                     o_alu_op,
  output logic                           o_alu_src2_imm,
  output logic                           o_gpr_wen,
  output logic                           o_mem_ren,
  output logic                           o_mem_wen,
  output logic                           o_ebreak,
  output logic                           o_invalid_inst,
  // forwarding sources
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]                i_es_result,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]                i_ms_result,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]                i_ws_result,
  input  logic                           i_es_load,
  input  logic                           i_ms_data_stall,
  // write-back port
  input  logic                           i_rf_wen,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_rf_waddr,
  input  logic [XLEN-1:0]                i_rf_wdata,
  // to fetch
  output logic                           o_br_taken,
  output logic [XLEN-1:0]                o_br_target,
  output logic                           o_br_stall
);

  logic                           ds_valid;
  id_pkg::inst_u                  ds_inst;
  logic [id_pkg::GPR_ADDR_WD-1:0] rs1;
  logic [id_pkg::GPR_ADDR_WD-1:0] rs2;
  logic [XLEN-1:0]                rf_rdata1;
  logic [XLEN-1:0]                rf_rdata2;
  logic                           br_eq;
  logic                           br_ne;
  logic                           jal;
  logic                           load_stall;
  logic                           stall;

  id_stage_reg #(.XLEN(XLEN)) u_stage_reg (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_stall          (stall),
    .i_br_taken       (o_br_taken),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_valid          (ds_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  inst_decoder #(.XLEN(XLEN)) u_decoder (
    .i_inst           (ds_inst),
    .o_rs1            (rs1),
    .o_rs2            (rs2),
    .o_rd             (o_rd),
    .o_imm            (o_imm),
    .o_alu_op         (o_alu_op),
    .o_alu_src2_imm   (o_alu_src2_imm),
    .o_gpr_wen        (o_gpr_wen),
    .o_mem_ren        (o_mem_ren),
    .o_mem_wen        (o_mem_wen),
    .o_br_eq          (br_eq),
    .o_br_ne          (br_ne),
    .o_jal            (jal),
    .o_ebreak         (o_ebreak),
    .o_invalid_inst   (o_invalid_inst)
  );

  gpr_file #(.XLEN(XLEN)) u_gpr_file (
    .i_clk            (i_clk),
    .i_raddr1         (rs1),
    .i_raddr2         (rs2),
    .i_wen            (i_rf_wen),
    .i_waddr          (i_rf_waddr),
    .i_wdata          (i_rf_wdata),
    .o_rdata1         (rf_rdata1),
    .o_rdata2         (rf_rdata2)
  );

  bypass_unit #(.XLEN(XLEN)) u_bypass (
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_rf_data1       (rf_rdata1),
    .i_rf_data2       (rf_rdata2),
    .i_es_rd          (i_es_rd),
    .i_es_result      (i_es_result),
    .i_ms_rd          (i_ms_rd),
    .i_ms_result      (i_ms_result),
    .i_ws_rd          (i_ws_rd),
    .i_ws_result      (i_ws_result),
    .i_es_load        (i_es_load),
    .i_ms_data_stall  (i_ms_data_stall),
    .o_rs1_data       (o_rs1_data),
    .o_rs2_data       (o_rs2_data),
    .o_load_stall     (load_stall),
    .o_stall          (stall)
  );

  branch_unit #(.XLEN(XLEN)) u_branch (
    .i_valid          (ds_valid),
    .i_pc             (o_pc),
    .i_imm            (o_imm),
    .i_rs1_data       (o_rs1_data),
    .i_rs2_data       (o_rs2_data),
    .i_br_eq          (br_eq),
    .i_br_ne          (br_ne),
    .i_jal            (jal),
    .i_load_stall     (load_stall),
    .o_br_taken       (o_br_taken),
    .o_br_target      (o_br_target),
    .o_br_stall       (o_br_stall)
  );

endmodule

//--- design/id_stage_reg.sv
// decode stage valid, instruction and pc register with allowin and branch squash
`timescale 1ns/1ps

module id_stage_reg #(
  parameter int XLEN = 64
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_fs_valid,
  input  logic [id_pkg::INST_WD-1:0] i_fs_inst,
  input  logic [XLEN-1:0]            i_fs_pc,
  input  logic                       i_es_allowin,
  input  logic                       i_stall,
  input  logic                       i_br_taken,
  output logic                       o_ds_allowin,
  output logic                       o_ds_to_es_valid,
  output logic                       o_valid,
  output id_pkg::inst_u              o_inst,
  output logic [XLEN-1:0]            o_pc
);

  logic ready_go;
  logic capture;

  assign ready_go         = ~i_stall;
  assign o_ds_allowin     = ~o_valid | (ready_go & i_es_allowin);
  assign o_ds_to_es_valid = o_valid & ready_go;
  assign capture          = i_fs_valid & o_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      o_valid <= i_fs_valid;
    end
  end

  // word fetched down the wrong path becomes a nop, pc kept
  always_ff @(posedge i_clk) begin
    if (capture) begin
      o_inst <= i_br_taken ? id_pkg::NOP_INST : i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

  // stalled instruction is not passed on and is still held next cycle
  a_stall_holds : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && i_stall) |-> !o_ds_to_es_valid ##1 (o_valid && $stable(o_pc))
  );

endmodule

//--- design/branch_unit.sv
// branch compare, jal, taken flag, target and branch stall
`timescale 1ns/1ps

module branch_unit #(
  parameter int XLEN = 64
) (
  input  logic            i_valid,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic            i_br_eq,
  input  logic            i_br_ne,
  input  logic            i_jal,
  input  logic            i_load_stall,
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target,
  output logic            o_br_stall
);

  logic equal;

  assign equal       = (i_rs1_data == i_rs2_data);
  assign o_br_taken  = i_valid & (i_jal | (i_br_eq & equal) | (i_br_ne & ~equal));
  assign o_br_target = i_pc + i_imm;
  assign o_br_stall  = o_br_taken & i_load_stall;

endmodule

//--- design/bypass_unit.sv
// operand forwarding muxes, load-use and memory-data stall detection
`timescale 1ns/1ps

module bypass_unit #(
  parameter int XLEN = 64
) (
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_rs1,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_rs2,
  input  logic [XLEN-1:0]                i_rf_data1,
  input  logic [XLEN-1:0]                i_rf_data2,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]                i_es_result,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]                i_ms_result,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]                i_ws_result,
  input  logic                           i_es_load,
  input  logic                           i_ms_data_stall,
  output logic [XLEN-1:0]                o_rs1_data,
  output logic [XLEN-1:0]                o_rs2_data,
  output logic                           o_load_stall,
  output logic                           o_stall
);

  logic es_hit1;
  logic es_hit2;
  logic ms_hit1;
  logic ms_hit2;
  logic ws_hit1;
  logic ws_hit2;
  logic ms_sel;

  function automatic logic src_hit(
    input logic [id_pkg::GPR_ADDR_WD-1:0] src_rd,
    input logic [id_pkg::GPR_ADDR_WD-1:0] rs
  );
    return (src_rd != '0) && (src_rd == rs); // x0 never forwards
  endfunction

  assign es_hit1 = src_hit(i_es_rd, i_rs1);
  assign es_hit2 = src_hit(i_es_rd, i_rs2);
  assign ms_hit1 = src_hit(i_ms_rd, i_rs1);
  assign ms_hit2 = src_hit(i_ms_rd, i_rs2);
  assign ws_hit1 = src_hit(i_ws_rd, i_rs1);
  assign ws_hit2 = src_hit(i_ws_rd, i_rs2);

  // youngest producer wins
  assign o_rs1_data = es_hit1 ? i_es_result :
                      ms_hit1 ? i_ms_result :
                      ws_hit1 ? i_ws_result : i_rf_data1;
  assign o_rs2_data = es_hit2 ? i_es_result :
                      ms_hit2 ? i_ms_result :
                      ws_hit2 ? i_ws_result : i_rf_data2;

  // memory stage actually picked for an operand
  assign ms_sel = (ms_hit1 & ~es_hit1) | (ms_hit2 & ~es_hit2);

  assign o_load_stall = i_es_load & (es_hit1 | es_hit2);
  assign o_stall      = o_load_stall | (i_ms_data_stall & ms_sel);

endmodule

//--- decode/inst_decoder.sv
// field extraction, immediate build and control decode for the supported subset
`timescale 1ns/1ps

module inst_decoder #(
  parameter int XLEN = 64
) (
  input  id_pkg::inst_u                  i_inst,
  output logic [id_pkg::GPR_ADDR_WD-1:0] o_rs1,
  output logic [id_pkg::GPR_ADDR_WD-1:0] o_rs2,
  output logic [id_pkg::GPR_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]                o_imm,
  output logic [1:0]                     o_alu_op,
  output logic                           o_alu_src2_imm,
  output logic                           o_gpr_wen,
  output logic                           o_mem_ren,
  output logic                           o_mem_wen,
  output logic                           o_br_eq,
  output logic                           o_br_ne,
  output logic                           o_jal,
  output logic                           o_ebreak,
  output logic                           o_invalid_inst
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_sel;
  logic        legal;
  logic        use_rs1;
  logic        use_rs2;
  logic        use_rd;
  logic [1:0]  alu_op;
  logic        src2_imm;
  logic        ld_sel;
  logic        st_sel;
  logic        beq_sel;
  logic        bne_sel;
  logic        jal_sel;
  logic        ebreak_sel;

  assign imm_i = {{20{i_inst.r.funct7[6]}}, i_inst.r.funct7, i_inst.r.rs2};
  assign imm_s = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
  assign imm_b = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_lo[0], i_inst.s.imm_hi[5:0],
                  i_inst.s.imm_lo[4:1], 1'b0};
  assign imm_u = {i_inst.u.imm20, 12'b0};
  assign imm_j = {{12{i_inst.u.imm20[19]}}, i_inst.u.imm20[7:0], i_inst.u.imm20[8],
                  i_inst.u.imm20[18:9], 1'b0};

  always_comb begin
    legal      = 1'b1;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    use_rd     = 1'b0;
    imm_sel    = '0;
    alu_op     = id_pkg::ALU_ADD;
    src2_imm   = 1'b0;
    ld_sel     = 1'b0;
    st_sel     = 1'b0;
    beq_sel    = 1'b0;
    bne_sel    = 1'b0;
    jal_sel    = 1'b0;
    ebreak_sel = 1'b0;
    case (i_inst.r.opcode)
      id_pkg::OPC_LUI: begin
        use_rd   = 1'b1;
        imm_sel  = imm_u;
        alu_op   = id_pkg::ALU_PASS_B;
        src2_imm = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        use_rd  = 1'b1;
        imm_sel = imm_j;
        jal_sel = 1'b1; // link value formed in execute
      end
      id_pkg::OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm_sel = imm_b;
        alu_op  = id_pkg::ALU_SUB;
        beq_sel = (i_inst.s.funct3 == id_pkg::F3_BEQ);
        bne_sel = (i_inst.s.funct3 == id_pkg::F3_BNE);
        legal   = beq_sel | bne_sel;
      end
      id_pkg::OPC_LOAD: begin
        use_rs1  = 1'b1;
        use_rd   = 1'b1;
        imm_sel  = imm_i;
        src2_imm = 1'b1;
        ld_sel   = 1'b1;
        legal    = (i_inst.r.funct3 == id_pkg::F3_DWORD);
      end
      id_pkg::OPC_STORE: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        imm_sel  = imm_s;
        src2_imm = 1'b1;
        st_sel   = 1'b1;
        legal    = (i_inst.s.funct3 == id_pkg::F3_DWORD);
      end
      id_pkg::OPC_OPIMM: begin
        use_rs1  = 1'b1;
        use_rd   = 1'b1;
        imm_sel  = imm_i;
        src2_imm = 1'b1;
        legal    = (i_inst.r.funct3 == id_pkg::F3_ADD);
      end
      id_pkg::OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
        alu_op  = (i_inst.r.funct7 == id_pkg::F7_SUB) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
        legal   = (i_inst.r.funct3 == id_pkg::F3_ADD) &&
                  ((i_inst.r.funct7 == id_pkg::F7_BASE) || (i_inst.r.funct7 == id_pkg::F7_SUB));
      end
      id_pkg::OPC_SYSTEM: begin
        // only ebreak, all other fields fixed
        ebreak_sel = 1'b1;
        legal      = (i_inst.r.funct7 == 7'd0) && (i_inst.r.rs2 == 5'd1) &&
                     (i_inst.r.rs1 == 5'd0) && (i_inst.r.funct3 == 3'd0) &&
                     (i_inst.r.rd == 5'd0);
      end
      default: legal = 1'b0;
    endcase
  end

  assign o_rs1          = (legal && use_rs1) ? i_inst.r.rs1 : '0;
  assign o_rs2          = (legal && use_rs2) ? i_inst.r.rs2 : '0;
  assign o_rd           = (legal && use_rd) ? i_inst.r.rd : '0;
  assign o_imm          = legal ? XLEN'($signed(imm_sel)) : '0;
  assign o_alu_op       = alu_op;
  assign o_alu_src2_imm = legal & src2_imm;
  assign o_gpr_wen      = |o_rd; // x0 target is no write
  assign o_mem_ren      = legal & ld_sel;
  assign o_mem_wen      = legal & st_sel;
  assign o_br_eq        = legal & beq_sel;
  assign o_br_ne        = legal & bne_sel;
  assign o_jal          = legal & jal_sel;
  assign o_ebreak       = legal & ebreak_sel;
  assign o_invalid_inst = ~legal;

  always_comb begin
    a_mem_onehot : assert final (!(o_mem_ren && o_mem_wen))
      else $error("load and store decoded from one word");
  end

endmodule

//--- design/gpr_file.sv
// 32-entry register file, two async read ports, one sync write port
`timescale 1ns/1ps

module gpr_file #(
  parameter int XLEN = 64
) (
  input  logic                           i_clk,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_raddr2,
  input  logic                           i_wen,
  input  logic [id_pkg::GPR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]                i_wdata,
  output logic [XLEN-1:0]                o_rdata1,
  output logic [XLEN-1:0]                o_rdata2
);

  logic [XLEN-1:0] regs [2**id_pkg::GPR_ADDR_WD];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 hardwired
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // read after write sees new data, x0 stays zero
  a_write_read : assert property (
    @(posedge i_clk)
    (i_wen ##1 (i_raddr1 == $past(i_waddr))) |->
      (o_rdata1 == (($past(i_waddr) == '0) ? '0 : $past(i_wdata)))
  );

endmodule

//--- common/id_pkg.sv
// decode stage widths, opcodes, funct codes, alu and branch codes, instruction union
package id_pkg;

  localparam int XLEN_DEFAULT = 64;
  localparam int INST_WD      = 32;
  localparam int GPR_ADDR_WD  = 5;

  // addi x0, x0, 0
  localparam logic [INST_WD-1:0] NOP_INST = 32'h0000_0013;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // branch compare kinds, by funct3
  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_DWORD = 3'b011; // ld / sd size
  localparam logic [2:0] F3_ADD   = 3'b000;

  localparam logic [6:0] F7_BASE  = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;

  localparam logic [1:0] ALU_ADD    = 2'd0;
  localparam logic [1:0] ALU_SUB    = 2'd1;
  localparam logic [1:0] ALU_PASS_B = 2'd2; // lui

  // one instruction word, three field views
  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [GPR_ADDR_WD-1:0] rs2;
      logic [GPR_ADDR_WD-1:0] rs1;
      logic [2:0]             funct3;
      logic [GPR_ADDR_WD-1:0] rd;
      logic [6:0]             opcode;
    } r;
    struct packed {
      logic [6:0]             imm_hi;
      logic [GPR_ADDR_WD-1:0] rs2;
      logic [GPR_ADDR_WD-1:0] rs1;
      logic [2:0]             funct3;
      logic [4:0]             imm_lo;
      logic [6:0]             opcode;
    } s; // s and b formats
    struct packed {
      logic [19:0]            imm20;
      logic [GPR_ADDR_WD-1:0] rd;
      logic [6:0]             opcode;
    } u; // u and j formats
  } inst_u;

endpackage
